//--- design/udp_engine_pkg.sv
package udp_engine_pkg;

    // ----------------------------------------------------------
    // Endpoint types
    // ----------------------------------------------------------
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    typedef struct packed {
        ip_addr_t  ip;
        udp_port_t port;
    } conn_key_t;

    // do_bind set binds the key, clear unbinds it
    typedef struct packed {
        conn_key_t key;
        logic      do_bind;
    } conn_req_t;

    // Same layout as status register bits 2:0
    typedef struct packed {
        logic done;
        logic full;
        logic ack;
    } conn_status_t;

    // ----------------------------------------------------------
    // Register map
    // ----------------------------------------------------------
    localparam int CSR_ADDR_WIDTH = 7;

    typedef logic [CSR_ADDR_WIDTH-1:0] csr_addr_t;
    typedef logic [31:0]               csr_data_t;

    localparam csr_addr_t CSR_CTRL       = 7'h00;
    localparam csr_addr_t CSR_WR_IP      = 7'h1C;
    localparam csr_addr_t CSR_WR_PORT    = 7'h20;
    localparam csr_addr_t CSR_WR_BIND    = 7'h24;
    localparam csr_addr_t CSR_WR_TRIGGER = 7'h28;
    localparam csr_addr_t CSR_WR_STATUS  = 7'h2C;
    localparam csr_addr_t CSR_WR_CONN_ID = 7'h30;

    // Forward lookup, request to result
    localparam int LOOKUP_LATENCY = 2;

    // Fold key to 32 bits, then multiplicative hash with golden ratio constant
    function automatic logic [15:0] hash_ip_port(input ip_addr_t ip, input udp_port_t port);
        logic [47:0] key;
        logic [31:0] mix;
        key = {ip, port};
        mix = key[31:0] ^ {key[47:32], key[15:0]};
        mix = mix * 32'h9E3779B1;
        return mix[31:16];
    endfunction

endpackage

//--- design/csr_regs.sv
`timescale 1ns/1ps

module csr_regs #(
    parameter int CONN_ID_WIDTH = 5
) (
    input  logic                         rx_axis_aclk,
    input  logic                         s_axi_aresetn,

    input  logic                         csr_wr_en,
    input  udp_engine_pkg::csr_addr_t    csr_wr_addr,
    input  udp_engine_pkg::csr_data_t    csr_wr_data,
    input  logic                         csr_rd_en,
    input  udp_engine_pkg::csr_addr_t    csr_rd_addr,
    output logic                         csr_rd_valid,
    output udp_engine_pkg::csr_data_t    csr_rd_data,

    output logic                         rx_enable,

    output logic                         conn_req_valid,
    output udp_engine_pkg::conn_req_t    conn_req,
    input  logic                         conn_rsp_valid,
    input  udp_engine_pkg::conn_status_t conn_rsp,
    input  logic [CONN_ID_WIDTH-1:0]     conn_rsp_id
);

    udp_engine_pkg::csr_data_t    ctrl_q;
    udp_engine_pkg::ip_addr_t     ip_q;
    udp_engine_pkg::udp_port_t    port_q;
    logic                         bind_q;
    udp_engine_pkg::conn_status_t status_q;
    logic [CONN_ID_WIDTH-1:0]     conn_id_q;
    logic                         busy;
    logic                         trigger_accept;

    assign rx_enable = ctrl_q[1];

    // Only one request in flight, later triggers are dropped
    assign trigger_accept = csr_wr_en && (csr_wr_addr == udp_engine_pkg::CSR_WR_TRIGGER)
                            && csr_wr_data[0] && !busy;

    // ----------------------------------------------------------
    // Write decode
    // ----------------------------------------------------------
    always_ff @(posedge rx_axis_aclk) begin
        if (!s_axi_aresetn) begin
            ctrl_q <= '0;
            ip_q   <= '0;
            port_q <= '0;
            bind_q <= 1'b0;
        end else if (csr_wr_en) begin
            case (csr_wr_addr)
                udp_engine_pkg::CSR_CTRL:    ctrl_q <= csr_wr_data;
                udp_engine_pkg::CSR_WR_IP:   ip_q   <= csr_wr_data;
                udp_engine_pkg::CSR_WR_PORT: port_q <= csr_wr_data[15:0];
                udp_engine_pkg::CSR_WR_BIND: bind_q <= csr_wr_data[0];
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Connection request and response capture
    // ----------------------------------------------------------
    always_ff @(posedge rx_axis_aclk) begin
        if (!s_axi_aresetn) begin
            conn_req_valid <= 1'b0;
            busy           <= 1'b0;
            status_q       <= '0;
            conn_id_q      <= '0;
        end else begin
            conn_req_valid <= trigger_accept;
            if (conn_rsp_valid) begin
                busy          <= 1'b0;
                status_q      <= conn_rsp;
                // Done marks that an answer came back, even a failed one
                status_q.done <= 1'b1;
                conn_id_q     <= conn_rsp_id;
            end else if (trigger_accept) begin
                busy      <= 1'b1;
                status_q  <= '0;
                conn_id_q <= '0;
            end
        end
    end

    // Snapshot of the endpoint registers
    always_ff @(posedge rx_axis_aclk) begin
        if (trigger_accept) begin
            conn_req.key.ip   <= ip_q;
            conn_req.key.port <= port_q;
            conn_req.do_bind  <= bind_q;
        end
    end

    // ----------------------------------------------------------
    // Registered read
    // ----------------------------------------------------------
    always_ff @(posedge rx_axis_aclk) begin
        if (!s_axi_aresetn) begin
            csr_rd_valid <= 1'b0;
            csr_rd_data  <= '0;
        end else begin
            csr_rd_valid <= csr_rd_en;
            if (csr_rd_en) begin
                case (csr_rd_addr)
                    udp_engine_pkg::CSR_CTRL:       csr_rd_data <= ctrl_q;
                    udp_engine_pkg::CSR_WR_IP:      csr_rd_data <= ip_q;
                    udp_engine_pkg::CSR_WR_PORT:    csr_rd_data <= {16'h0000, port_q};
                    udp_engine_pkg::CSR_WR_BIND:    csr_rd_data <= {31'h0, bind_q};
                    udp_engine_pkg::CSR_WR_STATUS:  csr_rd_data <= {29'h0, status_q};
                    udp_engine_pkg::CSR_WR_CONN_ID:
                        csr_rd_data <= udp_engine_pkg::csr_data_t'(conn_id_q);
                    default:                        csr_rd_data <= '0;
                endcase
            end
        end
    end

endmodule

//--- design/conn_table.sv
`timescale 1ns/1ps

module conn_table #(
    parameter int WAYS          = 2,
    parameter int HASH_BITS     = 4,
    parameter int CONN_ID_WIDTH = 5
) (
    input  logic                         rx_axis_aclk,
    input  logic                         s_axi_aresetn,
    input  logic                         rx_enable,

    input  logic                         conn_req_valid,
    input  udp_engine_pkg::conn_req_t    conn_req,
    output logic                         conn_rsp_valid,
    output udp_engine_pkg::conn_status_t conn_rsp,
    output logic [CONN_ID_WIDTH-1:0]     conn_rsp_id,

    input  logic                         lookup_valid,
    input  udp_engine_pkg::conn_key_t    lookup_key,
    output logic                         lookup_result_valid,
    output logic                         lookup_hit,
    output logic [CONN_ID_WIDTH-1:0]     lookup_conn_id
);

    localparam int SETS = 1 << HASH_BITS;

    logic [WAYS-1:0]              valid_mem [SETS];
    udp_engine_pkg::conn_key_t    key_mem   [SETS][WAYS];

    logic [HASH_BITS-1:0]         req_idx;
    logic                         rq_valid;
    udp_engine_pkg::conn_req_t    rq_req;
    logic [HASH_BITS-1:0]         rq_idx;
    logic [WAYS-1:0]              rq_set_valid;
    udp_engine_pkg::conn_key_t    rq_set_keys [WAYS];
    logic                         rq_match;
    logic [WAYS-1:0]              rq_match_oh;
    logic [CONN_ID_WIDTH-1:0]     rq_match_id;
    logic                         rq_free;
    logic [WAYS-1:0]              rq_free_oh;
    logic [CONN_ID_WIDTH-1:0]     rq_free_id;
    logic [WAYS-1:0]              set_oh;
    logic [WAYS-1:0]              clr_oh;
    udp_engine_pkg::conn_status_t rsp_next;
    logic [CONN_ID_WIDTH-1:0]     rsp_id_next;

    logic [HASH_BITS-1:0]         lookup_idx;
    logic                         lk_valid;
    logic                         lk_en;
    udp_engine_pkg::conn_key_t    lk_key;
    logic [WAYS-1:0]              lk_set_valid;
    udp_engine_pkg::conn_key_t    lk_set_keys [WAYS];
    logic                         lk_hit;
    logic [CONN_ID_WIDTH-1:0]     lk_id;

    // Top bits of the hash pick the set
    function automatic logic [HASH_BITS-1:0] set_index(input udp_engine_pkg::conn_key_t key);
        logic [15:0] h;
        h = udp_engine_pkg::hash_ip_port(key.ip, key.port);
        return h[15 -: HASH_BITS];
    endfunction

    // Index in the upper bits, way in the lower bits
    function automatic logic [CONN_ID_WIDTH-1:0] make_id(input logic [HASH_BITS-1:0] idx,
                                                         input int way);
        return CONN_ID_WIDTH'(idx) * CONN_ID_WIDTH'(WAYS) + CONN_ID_WIDTH'(way);
    endfunction

    assign req_idx    = set_index(conn_req.key);
    assign lookup_idx = set_index(lookup_key);

    // ----------------------------------------------------------
    // Bind and unbind, set read then commit
    // ----------------------------------------------------------
    always_ff @(posedge rx_axis_aclk) begin
        if (conn_req_valid) begin
            rq_req       <= conn_req;
            rq_idx       <= req_idx;
            rq_set_valid <= valid_mem[req_idx];
            for (int w = 0; w < WAYS; w++) begin
                rq_set_keys[w] <= key_mem[req_idx][w];
            end
        end
    end

    // Lowest matching way and lowest free way
    always_comb begin
        rq_match    = 1'b0;
        rq_match_oh = '0;
        rq_match_id = '0;
        rq_free     = 1'b0;
        rq_free_oh  = '0;
        rq_free_id  = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (!rq_match && rq_set_valid[w] && (rq_set_keys[w] == rq_req.key)) begin
                rq_match       = 1'b1;
                rq_match_oh[w] = 1'b1;
                rq_match_id    = make_id(rq_idx, w);
            end
            if (!rq_free && !rq_set_valid[w]) begin
                rq_free       = 1'b1;
                rq_free_oh[w] = 1'b1;
                rq_free_id    = make_id(rq_idx, w);
            end
        end
    end

    always_comb begin
        set_oh        = '0;
        clr_oh        = '0;
        rsp_next      = '0;
        rsp_next.done = 1'b1;
        rsp_id_next   = '0;
        if (rq_req.do_bind) begin
            if (rq_match) begin
                // Already bound, hand back the same id
                rsp_next.ack = 1'b1;
                rsp_id_next  = rq_match_id;
            end else if (rq_free) begin
                set_oh       = rq_free_oh;
                rsp_next.ack = 1'b1;
                rsp_id_next  = rq_free_id;
            end else begin
                rsp_next.full = 1'b1;
            end
        end else if (rq_match) begin
            clr_oh       = rq_match_oh;
            rsp_next.ack = 1'b1;
            rsp_id_next  = rq_match_id;
        end
    end

    always_ff @(posedge rx_axis_aclk) begin
        if (!s_axi_aresetn) begin
            rq_valid       <= 1'b0;
            conn_rsp_valid <= 1'b0;
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
            end
        end else begin
            rq_valid       <= conn_req_valid;
            conn_rsp_valid <= rq_valid;
            if (rq_valid) begin
                valid_mem[rq_idx] <= (rq_set_valid | set_oh) & ~clr_oh;
            end
        end
    end

    always_ff @(posedge rx_axis_aclk) begin
        if (rq_valid) begin
            conn_rsp    <= rsp_next;
            conn_rsp_id <= rsp_id_next;
            for (int w = 0; w < WAYS; w++) begin
                if (set_oh[w]) begin
                    key_mem[rq_idx][w] <= rq_req.key;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Forward lookup, stage 1 hash and read
    // ----------------------------------------------------------
    always_ff @(posedge rx_axis_aclk) begin
        if (lookup_valid) begin
            lk_en        <= rx_enable;
            lk_key       <= lookup_key;
            lk_set_valid <= valid_mem[lookup_idx];
            for (int w = 0; w < WAYS; w++) begin
                lk_set_keys[w] <= key_mem[lookup_idx][w];
            end
        end
    end

    // Stage 2 compare ways, lowest match wins
    always_comb begin
        lk_hit = 1'b0;
        lk_id  = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (lk_set_valid[w] && (lk_set_keys[w] == lk_key)) begin
                lk_hit = 1'b1;
                lk_id  = make_id(set_index(lk_key), w);
            end
        end
    end

    always_ff @(posedge rx_axis_aclk) begin
        if (!s_axi_aresetn) begin
            lk_valid            <= 1'b0;
            lookup_result_valid <= 1'b0;
            lookup_hit          <= 1'b0;
            lookup_conn_id      <= '0;
        end else begin
            lk_valid            <= lookup_valid;
            lookup_result_valid <= lk_valid;
            lookup_hit          <= lk_valid && lk_en && lk_hit;
            lookup_conn_id      <= (lk_valid && lk_en && lk_hit) ? lk_id : '0;
        end
    end

endmodule

//--- design/udp_engine_ctrl.sv
`timescale 1ns/1ps

module udp_engine_ctrl #(
    parameter int  WAYS          = 2,
    parameter int  HASH_BITS     = 4,
    localparam int CONN_ID_WIDTH = HASH_BITS + $clog2(WAYS)
) (
    input  logic                      rx_axis_aclk,
    input  logic                      s_axi_aresetn,

    // Register port
    input  logic                      csr_wr_en,
    input  udp_engine_pkg::csr_addr_t csr_wr_addr,
    input  udp_engine_pkg::csr_data_t csr_wr_data,
    input  logic                      csr_rd_en,
    input  udp_engine_pkg::csr_addr_t csr_rd_addr,
    output logic                      csr_rd_valid,
    output udp_engine_pkg::csr_data_t csr_rd_data,

    // Receive path lookup
    input  logic                      lookup_valid,
    input  udp_engine_pkg::conn_key_t lookup_key,
    output logic                      lookup_result_valid,
    output logic                      lookup_hit,
    output logic [CONN_ID_WIDTH-1:0]  lookup_conn_id
);

    logic                         rx_enable;
    logic                         conn_req_valid;
    udp_engine_pkg::conn_req_t    conn_req;
    logic                         conn_rsp_valid;
    udp_engine_pkg::conn_status_t conn_rsp;
    logic [CONN_ID_WIDTH-1:0]     conn_rsp_id;

    // ----------------------------------------------------------
    // Software registers
    // ----------------------------------------------------------
    csr_regs #(
        .CONN_ID_WIDTH (CONN_ID_WIDTH)
    ) u_csr_regs (
        .rx_axis_aclk   (rx_axis_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .csr_wr_en      (csr_wr_en),
        .csr_wr_addr    (csr_wr_addr),
        .csr_wr_data    (csr_wr_data),
        .csr_rd_en      (csr_rd_en),
        .csr_rd_addr    (csr_rd_addr),
        .csr_rd_valid   (csr_rd_valid),
        .csr_rd_data    (csr_rd_data),
        .rx_enable      (rx_enable),
        .conn_req_valid (conn_req_valid),
        .conn_req       (conn_req),
        .conn_rsp_valid (conn_rsp_valid),
        .conn_rsp       (conn_rsp),
        .conn_rsp_id    (conn_rsp_id)
    );

    // ----------------------------------------------------------
    // Connection table
    // ----------------------------------------------------------
    conn_table #(
        .WAYS          (WAYS),
        .HASH_BITS     (HASH_BITS),
        .CONN_ID_WIDTH (CONN_ID_WIDTH)
    ) u_conn_table (
        .rx_axis_aclk        (rx_axis_aclk),
        .s_axi_aresetn       (s_axi_aresetn),
        .rx_enable           (rx_enable),
        .conn_req_valid      (conn_req_valid),
        .conn_req            (conn_req),
        .conn_rsp_valid      (conn_rsp_valid),
        .conn_rsp            (conn_rsp),
        .conn_rsp_id         (conn_rsp_id),
        .lookup_valid        (lookup_valid),
        .lookup_key          (lookup_key),
        .lookup_result_valid (lookup_result_valid),
        .lookup_hit          (lookup_hit),
        .lookup_conn_id      (lookup_conn_id)
    );

endmodule

//--- testbench/udp_engine_asserts.sv
`timescale 1ns/1ps

module udp_engine_asserts (
    input logic                         rx_axis_aclk,
    input logic                         s_axi_aresetn,
    input logic                         lookup_valid,
    input logic                         lookup_result_valid,
    input logic                         conn_rsp_valid,
    input udp_engine_pkg::conn_status_t conn_rsp
);

    logic lookup_seen;

    // Set by the first lookup after reset
    always_ff @(posedge rx_axis_aclk) begin
        if (!s_axi_aresetn) begin
            lookup_seen <= 1'b0;
        end else if (lookup_valid) begin
            lookup_seen <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Lookup pipeline timing
    // ----------------------------------------------------------
    lookup_gets_result: assert property (@(posedge rx_axis_aclk) disable iff (!s_axi_aresetn)
        lookup_valid |-> ##(udp_engine_pkg::LOOKUP_LATENCY) lookup_result_valid)
        else $error("lookup_result_valid missing after lookup_valid");

    result_has_lookup: assert property (@(posedge rx_axis_aclk) disable iff (!s_axi_aresetn)
        lookup_result_valid |-> $past(lookup_valid, udp_engine_pkg::LOOKUP_LATENCY))
        else $error("lookup_result_valid without a lookup issued before it");

    quiet_after_reset: assert property (@(posedge rx_axis_aclk) disable iff (!s_axi_aresetn)
        !lookup_seen |-> !lookup_result_valid)
        else $error("lookup_result_valid high before any lookup");

    // Full and ack are exclusive
    rsp_ack_full: assert property (@(posedge rx_axis_aclk) disable iff (!s_axi_aresetn)
        conn_rsp_valid |-> !(conn_rsp.ack && conn_rsp.full))
        else $error("conn_rsp shows ack and full together");

endmodule

bind udp_engine_ctrl udp_engine_asserts u_asserts (
    .rx_axis_aclk        (rx_axis_aclk),
    .s_axi_aresetn       (s_axi_aresetn),
    .lookup_valid        (lookup_valid),
    .lookup_result_valid (lookup_result_valid),
    .conn_rsp_valid      (conn_rsp_valid),
    .conn_rsp            (conn_rsp)
);

//--- testbench/tb_udp_engine.sv
`timescale 1ns/1ps

module tb_udp_engine;

    localparam int WAYS      = 2;
    localparam int HASH_BITS = 4;
    localparam int SETS      = 1 << HASH_BITS;
    localparam int ID_W      = HASH_BITS + $clog2(WAYS);
    localparam int POOL      = 12;
    localparam int TIMEOUT   = 50;

    logic                      rx_axis_aclk;
    logic                      s_axi_aresetn;
    logic                      csr_wr_en;
    udp_engine_pkg::csr_addr_t csr_wr_addr;
    udp_engine_pkg::csr_data_t csr_wr_data;
    logic                      csr_rd_en;
    udp_engine_pkg::csr_addr_t csr_rd_addr;
    logic                      csr_rd_valid;
    udp_engine_pkg::csr_data_t csr_rd_data;
    logic                      lookup_valid;
    udp_engine_pkg::conn_key_t lookup_key;
    logic                      lookup_result_valid;
    logic                      lookup_hit;
    logic [ID_W-1:0]           lookup_conn_id;

    logic [31:0]               seed;
    int                        error_count;
    int                        timeout_count;
    int                        cycle;
    udp_engine_pkg::conn_key_t pool [POOL];
    udp_engine_pkg::conn_key_t coll [WAYS+1];
    logic                      model_valid [SETS][WAYS];
    udp_engine_pkg::conn_key_t model_key [SETS][WAYS];

    // Expected lookup results, oldest first
    logic                      exp_hit_q [$];
    logic [ID_W-1:0]           exp_id_q [$];
    int                        exp_cycle_q [$];

    udp_engine_ctrl #(
        .WAYS      (WAYS),
        .HASH_BITS (HASH_BITS)
    ) dut (
        .rx_axis_aclk        (rx_axis_aclk),
        .s_axi_aresetn       (s_axi_aresetn),
        .csr_wr_en           (csr_wr_en),
        .csr_wr_addr         (csr_wr_addr),
        .csr_wr_data         (csr_wr_data),
        .csr_rd_en           (csr_rd_en),
        .csr_rd_addr         (csr_rd_addr),
        .csr_rd_valid        (csr_rd_valid),
        .csr_rd_data         (csr_rd_data),
        .lookup_valid        (lookup_valid),
        .lookup_key          (lookup_key),
        .lookup_result_valid (lookup_result_valid),
        .lookup_hit          (lookup_hit),
        .lookup_conn_id      (lookup_conn_id)
    );

    always #5 rx_axis_aclk = ~rx_axis_aclk;

    always @(posedge rx_axis_aclk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic udp_engine_pkg::conn_key_t random_key();
        logic [31:0] ip;
        logic [31:0] r;
        ip = next_random();
        r  = next_random();
        return {ip, r[15:0]};
    endfunction

    // Fold to 32 bits, multiply by the golden ratio constant, keep the top bits
    function automatic logic [HASH_BITS-1:0] model_index(input udp_engine_pkg::conn_key_t key);
        logic [31:0] folded;
        logic [31:0] product;
        folded  = key[31:0] ^ {key[47:32], key[15:0]};
        product = folded * 32'h9E3779B1;
        return product[31 -: HASH_BITS];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s actual 0x%h expected 0x%h", name, actual, expected);
            error_count++;
        end
    endtask

    // ----------------------------------------------------------
    // Register port, each task starts and ends 1 ns after an edge
    // ----------------------------------------------------------
    task automatic csr_write(input udp_engine_pkg::csr_addr_t addr,
                             input udp_engine_pkg::csr_data_t data);
        csr_wr_en   = 1'b1;
        csr_wr_addr = addr;
        csr_wr_data = data;
        @(posedge rx_axis_aclk);
        #1;
        csr_wr_en = 1'b0;
    endtask

    task automatic csr_read(input udp_engine_pkg::csr_addr_t addr,
                            output udp_engine_pkg::csr_data_t data);
        int n;
        csr_rd_en   = 1'b1;
        csr_rd_addr = addr;
        @(posedge rx_axis_aclk);
        #1;
        csr_rd_en = 1'b0;
        n = 0;
        while (!csr_rd_valid && n < TIMEOUT) begin
            @(posedge rx_axis_aclk);
            #1;
            n++;
        end
        if (!csr_rd_valid) begin
            $display("Timeout: read of register 0x%h never returned data", addr);
            timeout_count++;
        end
        data = csr_rd_data;
    endtask

    // Program endpoint, trigger, then poll status until done
    task automatic run_request(input udp_engine_pkg::conn_key_t key, input logic do_bind,
                               output logic [2:0] status, output logic [ID_W-1:0] id);
        udp_engine_pkg::csr_data_t data;
        int n;
        csr_write(udp_engine_pkg::CSR_WR_IP, key.ip);
        csr_write(udp_engine_pkg::CSR_WR_PORT, {16'h0000, key.port});
        csr_write(udp_engine_pkg::CSR_WR_BIND, {31'h0, do_bind});
        csr_write(udp_engine_pkg::CSR_WR_TRIGGER, 32'h1);
        n = 0;
        csr_read(udp_engine_pkg::CSR_WR_STATUS, data);
        while (!data[2] && n < TIMEOUT) begin
            csr_read(udp_engine_pkg::CSR_WR_STATUS, data);
            n++;
        end
        if (!data[2]) begin
            $display("Timeout: request for endpoint %h never set done", key);
            timeout_count++;
        end
        status = data[2:0];
        csr_read(udp_engine_pkg::CSR_WR_CONN_ID, data);
        id = data[ID_W-1:0];
    endtask

    // Reference table, bind and unbind rules
    task automatic model_request(input udp_engine_pkg::conn_key_t key, input logic do_bind,
                                 output logic [2:0] status, output logic [ID_W-1:0] id);
        logic [HASH_BITS-1:0] idx;
        int match;
        int free;
        idx   = model_index(key);
        match = -1;
        free  = -1;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (model_valid[idx][w] && model_key[idx][w] == key) begin
                match = w;
            end
            if (!model_valid[idx][w]) begin
                free = w;
            end
        end
        status = 3'b100;
        id     = '0;
        if (match >= 0) begin
            status[0] = 1'b1;
            id        = ID_W'(idx * WAYS + match);
            if (!do_bind) begin
                model_valid[idx][match] = 1'b0;
            end
        end else if (do_bind && free >= 0) begin
            model_valid[idx][free] = 1'b1;
            model_key[idx][free]   = key;
            status[0]              = 1'b1;
            id                     = ID_W'(idx * WAYS + free);
        end else if (do_bind) begin
            status[1] = 1'b1;
        end
    endtask

    task automatic check_request(input udp_engine_pkg::conn_key_t key, input logic do_bind,
                                 output logic [ID_W-1:0] got_id,
                                 output logic [ID_W-1:0] exp_id);
        logic [2:0] got_status;
        logic [2:0] exp_status;
        model_request(key, do_bind, exp_status, exp_id);
        run_request(key, do_bind, got_status, got_id);
        check_value("status", got_status, exp_status);
        check_value("conn_id", got_id, exp_id);
    endtask

    // ----------------------------------------------------------
    // Forward lookup
    // ----------------------------------------------------------
    task automatic collect_result();
        if (lookup_result_valid) begin
            if (exp_hit_q.size() == 0) begin
                $display("Lookup result arrived with no lookup outstanding");
                error_count++;
            end else begin
                check_value("lookup_latency", cycle - exp_cycle_q.pop_front(),
                            udp_engine_pkg::LOOKUP_LATENCY);
                check_value("lookup_hit", lookup_hit, exp_hit_q.pop_front());
                check_value("lookup_conn_id", lookup_conn_id, exp_id_q.pop_front());
            end
        end
    endtask

    task automatic run_lookups(input int count, input logic enabled);
        udp_engine_pkg::conn_key_t key;
        logic [HASH_BITS-1:0]      idx;
        logic                      hit;
        logic [ID_W-1:0]           id;
        logic [31:0]               r;
        int                        n;
        for (int i = 0; i < count; i++) begin
            r   = next_random();
            key = (r[3:0] == 4'h0) ? random_key() : pool[r[31:8] % POOL];
            idx = model_index(key);
            hit = 1'b0;
            id  = '0;
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (enabled && model_valid[idx][w] && model_key[idx][w] == key) begin
                    hit = 1'b1;
                    id  = ID_W'(idx * WAYS + w);
                end
            end
            exp_hit_q.push_back(hit);
            exp_id_q.push_back(id);
            exp_cycle_q.push_back(cycle);
            lookup_valid = 1'b1;
            lookup_key   = key;
            @(posedge rx_axis_aclk);
            #1;
            collect_result();
        end
        lookup_valid = 1'b0;
        n = 0;
        while (exp_hit_q.size() > 0 && n < TIMEOUT) begin
            @(posedge rx_axis_aclk);
            #1;
            collect_result();
            n++;
        end
        if (exp_hit_q.size() > 0) begin
            $display("Timeout: %0d lookups never returned a result", exp_hit_q.size());
            timeout_count++;
        end
    endtask

    initial begin
        udp_engine_pkg::csr_data_t data;
        logic [31:0]               ip;
        logic [31:0]               port;
        logic [31:0]               bind_val;
        logic [31:0]               r;
        logic [ID_W-1:0]           got;
        logic [ID_W-1:0]           exp;
        logic [ID_W-1:0]           id0;
        int                        found;
        int                        tries;

        seed          = 32'hd27f_36da;
        error_count   = 0;
        timeout_count = 0;
        cycle         = 0;
        rx_axis_aclk  = 1'b0;
        s_axi_aresetn = 1'b0;
        csr_wr_en     = 1'b0;
        csr_wr_addr   = '0;
        csr_wr_data   = '0;
        csr_rd_en     = 1'b0;
        csr_rd_addr   = '0;
        lookup_valid  = 1'b0;
        lookup_key    = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_key[s][w]   = '0;
            end
        end
        for (int i = 0; i < POOL; i++) begin
            pool[i] = random_key();
        end

        repeat (4) @(posedge rx_axis_aclk);
        #1;
        s_axi_aresetn = 1'b1;
        @(posedge rx_axis_aclk);
        #1;

        // Status and id start out clear
        csr_read(udp_engine_pkg::CSR_WR_STATUS, data);
        check_value("status after reset", data, 32'h0);
        csr_read(udp_engine_pkg::CSR_WR_CONN_ID, data);
        check_value("conn_id after reset", data, 32'h0);

        // ----------------------------------------------------------
        // Register readback
        // ----------------------------------------------------------
        for (int i = 0; i < 8; i++) begin
            ip       = next_random();
            port     = next_random();
            bind_val = next_random();
            csr_write(udp_engine_pkg::CSR_WR_IP, ip);
            csr_write(udp_engine_pkg::CSR_WR_PORT, port);
            csr_write(udp_engine_pkg::CSR_WR_BIND, bind_val);
            csr_read(udp_engine_pkg::CSR_WR_IP, data);
            check_value("ip register", data, ip);
            csr_read(udp_engine_pkg::CSR_WR_PORT, data);
            check_value("port register", data, {16'h0000, port[15:0]});
            csr_read(udp_engine_pkg::CSR_WR_BIND, data);
            check_value("bind register", data, {31'h0, bind_val[0]});
        end

        // ----------------------------------------------------------
        // Full set, unbind and way reuse on one index
        // ----------------------------------------------------------
        coll[0] = random_key();
        found   = 1;
        tries   = 0;
        while (found < WAYS + 1 && tries < 10000) begin
            coll[found] = random_key();
            if (model_index(coll[found]) == model_index(coll[0])) begin
                found++;
            end
            tries++;
        end
        if (found < WAYS + 1) begin
            $display("Could not find enough endpoints that share one table index");
            error_count++;
        end
        check_request(coll[0], 1'b1, got, id0);
        check_request(coll[1], 1'b1, got, exp);
        check_request(coll[2], 1'b1, got, exp);
        check_request(coll[0], 1'b0, got, exp);
        check_value("unbind conn_id", got, id0);
        check_request(coll[2], 1'b1, got, exp);
        check_value("reused conn_id", got, id0);
        check_request(coll[0], 1'b0, got, exp);

        // ----------------------------------------------------------
        // Random binds and unbinds over the endpoint pool
        // ----------------------------------------------------------
        check_request(pool[0], 1'b1, got, id0);
        check_request(pool[0], 1'b1, got, exp);
        check_value("rebind conn_id", got, id0);
        for (int i = 0; i < 40; i++) begin
            r = next_random();
            check_request(pool[r[31:8] % POOL], r[1] | r[2], got, exp);
        end

        // Lookups with receive enable set, then clear
        csr_write(udp_engine_pkg::CSR_CTRL, 32'h2);
        csr_read(udp_engine_pkg::CSR_CTRL, data);
        check_value("ctrl register", data, 32'h2);
        run_lookups(40, 1'b1);
        csr_write(udp_engine_pkg::CSR_CTRL, 32'h0);
        run_lookups(16, 1'b0);

        $display("Checks done: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- project.f
design/udp_engine_pkg.sv
design/csr_regs.sv
design/conn_table.sv
design/udp_engine_ctrl.sv
testbench/udp_engine_asserts.sv
testbench/tb_udp_engine.sv
